// File: Makefile
# Verilator build and run for the floor request controller

VERILATOR ?= verilator
TOP       ?= floor_logic_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= All tests passed!

SOURCES := $(wildcard include/*.svh logic/*.sv verif/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail is taken from the log, not from the exit status
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/elevator_params.svh
/*
 * Sizing constants for the floor request controller.
 * Car state codes 0 up to LAST_STOP_STATE mean stopped at floors 1 to 11;
 * every higher code is a moving or emergency state.
 */
`ifndef ELEVATOR_PARAMS_SVH
`define ELEVATOR_PARAMS_SVH

// Building size
`define NUM_FLOORS       11
`define FLOOR_WIDTH      4

// One stack slot per floor is enough, a floor is never pending twice
`define STACK_DEPTH      11

// Car state machine encoding
`define CAR_STATE_WIDTH  6
`define LAST_STOP_STATE  10

`endif

// File: list.f
+incdir+include
logic/floor_pkg.sv
logic/car_pkg.sv
logic/button_capture.sv
logic/request_stack.sv
logic/car_command.sv
logic/floor_logic_control_unit.sv
verif/floor_logic_tb.sv

// File: logic/button_capture.sv
/*
 * Button latch and request selector. Accepts at most one new floor per cycle,
 * panel before call and lowest floor first. Presses are dropped while the
 * stack is full or a request is still in flight to the stack.
 */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_params.svh"

module button_capture (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire floor_pkg::floor_mask_t floor_call_buttons,
    input  wire floor_pkg::floor_mask_t panel_buttons,
    input  wire                        emergency_btn,
    input  wire                        power_switch,
    input  wire floor_pkg::floor_t     current_floor_state,
    input  wire car_pkg::car_state_t   elevator_state,
    input  wire                        stack_full,
    output floor_pkg::floor_mask_t     call_button_lights,
    output floor_pkg::floor_mask_t     panel_button_lights,
    output logic                       req_valid,
    output floor_pkg::floor_t          req_floor,
    output logic                       service_enabled,
    output logic                       car_stopped
);

    floor_pkg::floor_mask_t cur_mask;
    floor_pkg::floor_mask_t panel_cand;
    floor_pkg::floor_mask_t call_cand;
    floor_pkg::floor_mask_t pick_mask;
    floor_pkg::floor_mask_t stop_clear;
    floor_pkg::floor_mask_t panel_next;
    floor_pkg::floor_mask_t call_next;
    floor_pkg::floor_t      pick_floor;
    logic                   pick_panel;
    logic                   accept;
    logic                   other_lit;

    // Lowest set bit of a floor mask, 0 when the mask is empty
    function automatic floor_pkg::floor_t lowest_floor(input floor_pkg::floor_mask_t mask);
        floor_pkg::floor_t idx;
        idx = '0;
        for (int i = `NUM_FLOORS - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = floor_pkg::floor_t'(i);
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////
    // Status decode
    //////////////////////////////////////////////////

    assign service_enabled = power_switch && !emergency_btn;
    assign car_stopped     = (elevator_state <= car_pkg::car_state_t'(`LAST_STOP_STATE));

    always_comb begin
        for (int i = 0; i < `NUM_FLOORS; i++) begin
            cur_mask[i] = (current_floor_state == floor_pkg::floor_t'(i));
        end
    end

    //////////////////////////////////////////////////
    // Request selection
    //////////////////////////////////////////////////

    // Unlit presses away from the current floor
    assign panel_cand = panel_buttons & ~panel_button_lights & ~cur_mask;
    assign call_cand  = floor_call_buttons & ~call_button_lights & ~cur_mask;

    assign pick_panel = |panel_cand;
    assign pick_floor = pick_panel ? lowest_floor(panel_cand) : lowest_floor(call_cand);
    assign pick_mask  = floor_pkg::floor_mask_t'(1) << pick_floor;

    // A request already sitting in req_valid has not reached the stack count yet
    assign accept = service_enabled && !stack_full && !req_valid &&
                    (pick_panel || (|call_cand));

    // Floor already pending through its other button, light only
    assign other_lit = pick_panel ? (|(pick_mask & call_button_lights))
                                  : (|(pick_mask & panel_button_lights));

    assign stop_clear = car_stopped ? cur_mask : '0;

    always_comb begin
        panel_next = panel_button_lights;
        call_next  = call_button_lights;
        if (accept && pick_panel) begin
            panel_next = panel_next | pick_mask;
        end
        if (accept && !pick_panel) begin
            call_next = call_next | pick_mask;
        end
        // Served floor, both lamps go dark
        panel_next = panel_next & ~stop_clear;
        call_next  = call_next & ~stop_clear;
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
            req_valid           <= 1'b0;
        end else if (!service_enabled) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
            req_valid           <= 1'b0;
        end else begin
            call_button_lights  <= call_next;
            panel_button_lights <= panel_next;
            req_valid           <= accept && !other_lit;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_floor <= pick_floor;
        end
    end

endmodule

`default_nettype wire

// File: logic/car_command.sv
/*
 * Target floor, direction and activate level for the car FSM.
 * The car is only sent off from a stop; activate drops as soon as it moves.
 * Door permissions are combinational and need service on and the car stopped.
 */
`timescale 1ns/1ps
`default_nettype none

module car_command (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire floor_pkg::floor_t top_floor,
    input  wire                    stack_empty,
    input  wire                    service_enabled,
    input  wire                    car_stopped,
    input  wire floor_pkg::floor_t current_floor_state,
    input  wire                    door_open_btn,
    input  wire                    door_close_btn,
    output floor_pkg::floor_t      elevator_floor_selector,
    output logic                   direction_selector,
    output logic                   activate_elevator,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);

    logic send_car;

    // Pending target elsewhere while parked
    assign send_car = service_enabled && car_stopped && !stack_empty &&
                      (top_floor != current_floor_state);

    //////////////////////////////////////////////////
    // Target registers
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            elevator_floor_selector <= '0;
        end else if (!stack_empty) begin
            elevator_floor_selector <= top_floor;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator  <= 1'b0;
            direction_selector <= 1'b1;
        end else begin
            activate_elevator <= send_car;
            // Direction holds when there is nowhere to go
            if (send_car) begin
                direction_selector <= (top_floor > current_floor_state);
            end
        end
    end

    //////////////////////////////////////////////////
    // Door gating
    //////////////////////////////////////////////////

    assign door_open_allowed  = service_enabled && car_stopped && door_open_btn;
    assign door_close_allowed = service_enabled && car_stopped && door_close_btn;

endmodule

`default_nettype wire

// File: logic/car_pkg.sv
/*
 * State code reported by the external car state machine.
 * Only the stop/not-stop split is interpreted here.
 */
`default_nettype none

`include "elevator_params.svh"

package car_pkg;

    // Raw state code of the car FSM
    // 0..LAST_STOP_STATE are stops, the rest are travel or emergency
    typedef logic [`CAR_STATE_WIDTH-1:0] car_state_t;

endpackage

`default_nettype wire

// File: logic/floor_logic_control_unit.sv
/*
 * Floor request controller, sits beside the car state machine.
 * Press to target output takes three clocks; arrival pops on the next clock.
 * Power off or emergency clears all lamps and pending requests.
 */
`timescale 1ns/1ps
`default_nettype none

module floor_logic_control_unit (
    input  wire                         clock,
    input  wire                         reset_n,
    // Buttons
    input  wire floor_pkg::floor_mask_t floor_call_buttons,
    input  wire floor_pkg::floor_mask_t panel_buttons,
    input  wire                         door_open_btn,
    input  wire                         door_close_btn,
    input  wire                         emergency_btn,
    input  wire                         power_switch,
    // Car FSM status
    input  wire floor_pkg::floor_t      current_floor_state,
    input  wire car_pkg::car_state_t    elevator_state,
    // Car FSM commands
    output floor_pkg::floor_t           elevator_floor_selector,
    output logic                        direction_selector,
    output logic                        activate_elevator,
    output logic                        door_open_allowed,
    output logic                        door_close_allowed,
    // Lamps
    output floor_pkg::floor_mask_t      call_button_lights,
    output floor_pkg::floor_mask_t      panel_button_lights
);

    logic              req_valid;
    floor_pkg::floor_t req_floor;
    logic              service_enabled;
    logic              car_stopped;
    floor_pkg::floor_t top_floor;
    logic              stack_empty;
    logic              stack_full;

    button_capture i_button_capture (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor_state (current_floor_state),
        .elevator_state      (elevator_state),
        .stack_full          (stack_full),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .req_valid           (req_valid),
        .req_floor           (req_floor),
        .service_enabled     (service_enabled),
        .car_stopped         (car_stopped)
    );

    request_stack i_request_stack (
        .clock               (clock),
        .reset_n             (reset_n),
        .req_valid           (req_valid),
        .req_floor           (req_floor),
        .service_enabled     (service_enabled),
        .car_stopped         (car_stopped),
        .current_floor_state (current_floor_state),
        .top_floor           (top_floor),
        .stack_empty         (stack_empty),
        .stack_full          (stack_full)
    );

    car_command i_car_command (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .top_floor               (top_floor),
        .stack_empty             (stack_empty),
        .service_enabled         (service_enabled),
        .car_stopped             (car_stopped),
        .current_floor_state     (current_floor_state),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

// File: logic/floor_pkg.sv
/*
 * Floor numbers run from 0 (floor 1) to 10 (floor 11).
 * Masks carry one bit per floor, bit 0 is the lowest floor.
 */
`default_nettype none

`include "elevator_params.svh"

package floor_pkg;

    // Floor number as used by buttons, the stack and the car
    typedef logic [`FLOOR_WIDTH-1:0] floor_t;

    // One bit per floor, for buttons and lamps
    typedef logic [`NUM_FLOORS-1:0] floor_mask_t;

    // Fill count of the request stack, 0 up to STACK_DEPTH
    typedef logic [$clog2(`STACK_DEPTH + 1)-1:0] stack_ptr_t;

endpackage

`default_nettype wire

// File: logic/request_stack.sv
/*
 * Last-in, first-out store of pending floors.
 * The top entry pops only while the car is stopped at that floor.
 * A push while full is dropped; the button stage never sends one.
 */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_params.svh"

module request_stack (
    input  wire                    clock,
    input  wire                    reset_n,
    input  wire                    req_valid,
    input  wire floor_pkg::floor_t req_floor,
    input  wire                    service_enabled,
    input  wire                    car_stopped,
    input  wire floor_pkg::floor_t current_floor_state,
    output floor_pkg::floor_t      top_floor,
    output logic                   stack_empty,
    output logic                   stack_full
);

    floor_pkg::floor_t    stack_mem [`STACK_DEPTH];
    floor_pkg::stack_ptr_t count;
    floor_pkg::stack_ptr_t wr_ptr;
    logic                 pop;
    logic                 push;
    logic                 write_en;

    //////////////////////////////////////////////////
    // Status and top of stack
    //////////////////////////////////////////////////

    assign stack_empty = (count == '0);
    assign stack_full  = (count == floor_pkg::stack_ptr_t'(`STACK_DEPTH));
    assign top_floor   = stack_empty ? '0 : stack_mem[count - 1'b1];

    // Car has reached the floor on top
    assign pop  = car_stopped && !stack_empty && (top_floor == current_floor_state);
    assign push = req_valid;

    // Pop with push overwrites the top slot in place
    assign wr_ptr   = pop ? (count - 1'b1) : count;
    assign write_en = push && (pop || !stack_full);

    //////////////////////////////////////////////////
    // Fill count
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (!service_enabled) begin
            count <= '0;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end else if (push && !pop && !stack_full) begin
            count <= count + 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clock) begin
        if (write_en) begin
            stack_mem[wr_ptr] <= req_floor;
        end
    end

endmodule

`default_nettype wire

// File: verif/floor_logic_tb.sv
/*
 * Directed testbench for the floor request controller.
 * Car state code 20 stands for a moving car; codes 0 to 10 are stops.
 * The run stops at the first failing check or wait timeout.
 */
`timescale 1ns/1ps
`default_nettype none

`include "elevator_params.svh"

module floor_logic_tb;

    localparam car_pkg::car_state_t MOVING = 20;
    localparam int TIMEOUT      = 40;
    localparam int SIG_PANEL    = 0;
    localparam int SIG_CALL     = 1;
    localparam int SIG_ACTIVATE = 2;

    logic                   clock;
    logic                   reset_n;
    floor_pkg::floor_mask_t floor_call_buttons;
    floor_pkg::floor_mask_t panel_buttons;
    logic                   door_open_btn;
    logic                   door_close_btn;
    logic                   emergency_btn;
    logic                   power_switch;
    floor_pkg::floor_t      current_floor_state;
    car_pkg::car_state_t    elevator_state;
    floor_pkg::floor_t      elevator_floor_selector;
    logic                   direction_selector;
    logic                   activate_elevator;
    logic                   door_open_allowed;
    logic                   door_close_allowed;
    floor_pkg::floor_mask_t call_button_lights;
    floor_pkg::floor_mask_t panel_button_lights;

    // Reference stack with the top at the back of the queue
    floor_pkg::floor_t model_q[$];
    logic [31:0]       lfsr_state;

    floor_logic_control_unit i_dut (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights)
    );

    always #20 clock = ~clock;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic floor_pkg::floor_mask_t floor_bit(input int f);
        return floor_pkg::floor_mask_t'(1) << f;
    endfunction

    function automatic logic observe(input int which, input int f);
        case (which)
            SIG_PANEL: return panel_button_lights[f];
            SIG_CALL:  return call_button_lights[f];
            default:   return activate_elevator;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("[FAIL] %0t ns %s: actual 0x%0h, expected 0x%0h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic wait_output(input int which, input int f, input logic level,
                               input string what);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clock);
            seen = (observe(which, f) === level);
            cycles++;
        end
        if (!seen) begin
            report_failure($sformatf("Timed out after %0d cycles waiting for %s",
                                     TIMEOUT, what));
        end
    endtask

    task automatic press(input floor_pkg::floor_mask_t panel,
                         input floor_pkg::floor_mask_t call);
        @(posedge clock);
        panel_buttons      <= panel;
        floor_call_buttons <= call;
        @(posedge clock);
        panel_buttons      <= '0;
        floor_call_buttons <= '0;
    endtask

    task automatic set_car(input car_pkg::car_state_t state, input int f);
        @(posedge clock);
        elevator_state      <= state;
        current_floor_state <= floor_pkg::floor_t'(f);
    endtask

    task automatic set_service(input logic power, input logic emergency);
        @(posedge clock);
        power_switch  <= power;
        emergency_btn <= emergency;
    endtask

    // Drive both door buttons and check the gated outputs in the same cycle
    task automatic door_step(input logic open, input logic close, input logic allowed);
        @(posedge clock);
        door_open_btn  <= open;
        door_close_btn <= close;
        @(negedge clock);
        check_value("door_open_allowed", door_open_allowed, allowed && open);
        check_value("door_close_allowed", door_close_allowed, allowed && close);
    endtask

    task automatic check_lights(input floor_pkg::floor_mask_t panel,
                                input floor_pkg::floor_mask_t call);
        check_value("panel_button_lights", panel_button_lights, panel);
        check_value("call_button_lights", call_button_lights, call);
    endtask

    // Leave the current floor, then stop at the target
    task automatic travel_to(input int target);
        set_car(MOVING, current_floor_state);
        wait_output(SIG_ACTIVATE, 0, 1'b0, "activate to drop while moving");
        set_car(car_pkg::car_state_t'(target), target);
    endtask

    task automatic model_arrive(input int target);
        if (model_q.size() > 0 && model_q[$] == target) begin
            void'(model_q.pop_back());
        end
    endtask

    task automatic check_parked();
        repeat (2) @(negedge clock);
        check_value("activate_elevator", activate_elevator, 1'b0);
        check_value("stack_empty", i_dut.stack_empty, model_q.size() == 0);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_and_doors();
        $display("Test: reset and doors");
        check_lights('0, '0);
        check_value("activate_elevator", activate_elevator, 1'b0);
        check_value("elevator_floor_selector", elevator_floor_selector, 0);
        check_value("direction_selector", direction_selector, 1'b1);
        set_car(0, 0);
        door_step(1'b1, 1'b0, 1'b1);
        door_step(1'b0, 1'b1, 1'b1);
        set_car(MOVING, 0);
        door_step(1'b1, 1'b1, 1'b0);
        set_car(0, 0);
        set_service(1'b0, 1'b0);
        door_step(1'b1, 1'b1, 1'b0);
        set_service(1'b1, 1'b1);
        door_step(1'b1, 1'b1, 1'b0);
        set_service(1'b1, 1'b0);
        door_step(1'b0, 1'b0, 1'b1);
    endtask

    task automatic test_request_to_arrival();
        $display("Test: request to arrival");
        press(floor_bit(5), '0);
        wait_output(SIG_PANEL, 5, 1'b1, "panel light 5 on");
        model_q.push_back(5);
        wait_output(SIG_ACTIVATE, 0, 1'b1, "activate for floor 5");
        check_value("elevator_floor_selector", elevator_floor_selector, 5);
        check_value("direction_selector", direction_selector, 1'b1);
        travel_to(5);
        wait_output(SIG_PANEL, 5, 1'b0, "panel light 5 cleared");
        model_arrive(5);
        check_parked();
        press('0, floor_bit(2));
        wait_output(SIG_CALL, 2, 1'b1, "call light 2 on");
        model_q.push_back(2);
        wait_output(SIG_ACTIVATE, 0, 1'b1, "activate for floor 2");
        check_value("elevator_floor_selector", elevator_floor_selector, 2);
        check_value("direction_selector", direction_selector, 1'b0);
        travel_to(2);
        wait_output(SIG_CALL, 2, 1'b0, "call light 2 cleared");
        model_arrive(2);
        check_parked();
    endtask

    task automatic test_stack_order();
        floor_pkg::floor_mask_t used;
        int                     seq[$];
        int                     bits;
        int                     f;
        $display("Test: stack order");
        used = '0;
        set_car(MOVING, 0);
        while (seq.size() < 5) begin
            random_bits(4, bits);
            f = 1 + bits % 10;
            if (!used[f]) begin
                used[f] = 1'b1;
                seq.push_back(f);
                press(floor_bit(f), '0);
                wait_output(SIG_PANEL, f, 1'b1, $sformatf("panel light %0d on", f));
                model_q.push_back(floor_pkg::floor_t'(f));
            end
        end
        set_car(0, 0);
        wait_output(SIG_ACTIVATE, 0, 1'b1, "activate after stopping at floor 0");
        check_value("elevator_floor_selector", elevator_floor_selector, seq[$]);
        while (model_q.size() > 0) begin
            wait_output(SIG_ACTIVATE, 0, 1'b1, "activate for the next target");
            f = model_q[$];
            check_value("elevator_floor_selector", elevator_floor_selector, f);
            check_value("direction_selector", direction_selector, f > current_floor_state);
            travel_to(f);
            wait_output(SIG_PANEL, f, 1'b0, $sformatf("panel light %0d cleared", f));
            model_arrive(f);
        end
        check_parked();
        check_lights('0, '0);
    endtask

    task automatic test_filtering();
        $display("Test: filtering");
        // Passing floor 2 while moving, so a stop cannot hide the lamp
        set_car(MOVING, 2);
        press(floor_bit(2), floor_bit(2));
        repeat (3) @(negedge clock);
        check_lights('0, '0);
        set_car(2, 2);
        press(floor_bit(7), '0);
        wait_output(SIG_PANEL, 7, 1'b1, "panel light 7 on");
        model_q.push_back(7);
        press(floor_bit(7), '0);
        repeat (3) @(negedge clock);
        check_lights(floor_bit(7), '0);
        // Floor 7 already pending so only the call lamp lights
        press('0, floor_bit(7));
        wait_output(SIG_CALL, 7, 1'b1, "call light 7 on");
        check_lights(floor_bit(7), floor_bit(7));
        travel_to(7);
        wait_output(SIG_PANEL, 7, 1'b0, "panel light 7 cleared");
        check_lights('0, '0);
        model_arrive(7);
        // A second entry for floor 7 would still be on the stack here
        check_value("stack_empty", i_dut.stack_empty, model_q.size() == 0);
        check_parked();
        press(floor_bit(3), floor_bit(3));
        wait_output(SIG_PANEL, 3, 1'b1, "panel light 3 on");
        model_q.push_back(3);
        check_value("call_button_lights", call_button_lights, '0);
    endtask

    task automatic clear_pending(input logic power, input logic emergency);
        press(floor_bit(9), '0);
        wait_output(SIG_PANEL, 9, 1'b1, "panel light 9 on");
        press('0, floor_bit(1));
        wait_output(SIG_CALL, 1, 1'b1, "call light 1 on");
        wait_output(SIG_ACTIVATE, 0, 1'b1, "activate with requests pending");
        set_service(power, emergency);
        wait_output(SIG_PANEL, 9, 1'b0, "lights cleared by loss of service");
        check_lights('0, '0);
        model_q.delete();
        check_parked();
        set_service(1'b1, 1'b0);
        check_parked();
        check_lights('0, '0);
    endtask

    task automatic test_clearing();
        $display("Test: clearing");
        clear_pending(1'b1, 1'b1);
        clear_pending(1'b0, 1'b0);
    endtask

    initial begin
        clock               = 1'b0;
        reset_n             = 1'b0;
        floor_call_buttons  = '0;
        panel_buttons       = '0;
        door_open_btn       = 1'b0;
        door_close_btn      = 1'b0;
        emergency_btn       = 1'b0;
        power_switch        = 1'b1;
        current_floor_state = '0;
        elevator_state      = '0;
        lfsr_state          = 32'h8d09f963;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        test_reset_and_doors();
        test_request_to_arrival();
        test_stack_order();
        test_filtering();
        test_clearing();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
